// File: hw/datapath_config.svh
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// word width of the registers and the ALU
`define DATA_WIDTH 8

// general registers R0 to R3
`define REG_COUNT 4

// APB address map
`define APB_ADDR_WIDTH 4
`define ADDR_FLAGS     4   // read only flags just above R0..R3 at 0..3
`define ADDR_COMMAND   8   // write only micro-operation word

`endif

// File: hw/aluPkg.sv
package aluPkg;

   // ALU function codes
   // codes 3, 6, 9, 13 and 15 are not implemented
   typedef enum logic [3:0] {
      aluPassA           = 4'd0,
      aluPassB           = 4'd1,
      aluNotA            = 4'd2,
      aluAdd             = 4'd4,   // A + B + carry
      aluSub             = 4'd5,
      aluAnd             = 4'd7,
      aluOr              = 4'd8,
      aluXor             = 4'd10,
      aluShiftLeft       = 4'd11,
      aluShiftRight      = 4'd12,
      aluShiftRightArith = 4'd14
   } aluOp_t;

   // status flags with zero in the top bit
   typedef struct packed {
      logic zero;
      logic carry;
      logic negative;
      logic overflow;
   } aluFlags_t;

endpackage

// File: hw/commandPkg.sv
`include "datapath_config.svh"

package commandPkg;

   // per-register functions
   typedef enum logic [1:0] {
      funClear     = 2'd0,
      funLoad      = 2'd1,   // load immediate
      funDecrement = 2'd2,
      funIncrement = 2'd3
   } regFun_t;

   typedef logic [$clog2(`REG_COUNT)-1:0] regIndex_t;

   // register form has bit 15 set
   typedef struct packed {
      logic                   isRegForm;
      regFun_t                regFun;       // 14:13
      logic [1:0]             spareHigh;
      regIndex_t              destination;  // 10:9
      logic                   spareLow;
      logic [`DATA_WIDTH-1:0] immediate;    // 7:0
   } regForm_t;

   // ALU form has bit 15 clear
   typedef struct packed {
      logic           isRegForm;
      aluPkg::aluOp_t aluOp;        // 14:11
      regIndex_t      destination;  // 10:9 as in regForm
      regIndex_t      sourceA;      // 8:7
      regIndex_t      sourceB;      // 6:5
      logic [4:0]     spare;
   } aluForm_t;

   // one 16-bit command word read through whichever form bit 15 selects
   typedef union packed {
      regForm_t regForm;
      aluForm_t aluForm;
   } microOp_t;

endpackage

// File: hw/regAccessBus.sv
`timescale 1ns/1ps
`include "datapath_config.svh"

interface regAccessBus;

   // command fields
   logic                   writeEnable;
   commandPkg::regFun_t    regFun;
   commandPkg::regIndex_t  destination;
   commandPkg::regIndex_t  sourceA;
   commandPkg::regIndex_t  sourceB;
   logic [`DATA_WIDTH-1:0] immediate;
   logic                   useAlu;      // result instead of regFun
   aluPkg::aluOp_t         aluOp;

   logic [`DATA_WIDTH-1:0] operandA;
   logic [`DATA_WIDTH-1:0] operandB;
   logic [`DATA_WIDTH-1:0] result;

   modport commander (
      output writeEnable, regFun, destination, sourceA, sourceB, immediate, useAlu, aluOp,
      input  operandA
   );

   modport storage (
      input  writeEnable, regFun, destination, sourceA, sourceB, immediate, useAlu, result,
      output operandA, operandB
   );

   // useAlu gates the flag update
   modport compute (
      input  operandA, operandB, aluOp, writeEnable, useAlu,
      output result
   );

endinterface

// File: hw/apbCommandPort.sv
`timescale 1ns/1ps
`include "datapath_config.svh"

module apbCommandPort (
   input  logic                       clock,
   input  logic                       reset,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [`APB_ADDR_WIDTH-1:0] paddr,
   input  logic [15:0]                pwdata,
   output logic [15:0]                prdata,
   output logic                       pready,
   output logic                       pslverr,
   input  aluPkg::aluFlags_t          flags,
   regAccessBus.commander             bus
);

   localparam int INDEX_WIDTH = $bits(commandPkg::regIndex_t);

   commandPkg::microOp_t commandReg;   // captured micro-operation
   logic                 executePhase; // second access cycle of a command write

   logic accessCycle;
   logic commandWrite;
   logic validRead;
   logic flagsRead;

   // address decode
   assign accessCycle  = psel & penable;
   assign commandWrite = pwrite & (paddr == `APB_ADDR_WIDTH'(`ADDR_COMMAND));
   assign validRead    = ~pwrite & (paddr <= `APB_ADDR_WIDTH'(`ADDR_FLAGS));
   assign flagsRead    = paddr == `APB_ADDR_WIDTH'(`ADDR_FLAGS);

   always_ff @(posedge clock) begin
      if (reset) begin
         executePhase <= 1'b0;
      end else begin
         // set by the first access cycle, cleared by the second
         executePhase <= accessCycle & commandWrite & ~executePhase;
      end
   end

   always_ff @(posedge clock) begin
      if (accessCycle && commandWrite && !executePhase) begin
         commandReg <= pwdata;
      end
   end

   // one wait state on command writes, none on anything else
   assign pready  = accessCycle & (~commandWrite | executePhase);
   assign pslverr = accessCycle & ~commandWrite & ~validRead;

   assign bus.writeEnable = executePhase;
   assign bus.useAlu      = ~commandReg.regForm.isRegForm;
   assign bus.regFun      = commandReg.regForm.regFun;
   assign bus.immediate   = commandReg.regForm.immediate;
   assign bus.destination = commandReg.regForm.destination;
   assign bus.aluOp       = commandReg.aluForm.aluOp;
   assign bus.sourceB     = commandReg.aluForm.sourceB;

   // port A doubles as the host read port outside the execute cycle
   always_comb begin
      if (executePhase) begin
         bus.sourceA = commandReg.aluForm.sourceA;
      end else begin
         bus.sourceA = paddr[INDEX_WIDTH-1:0];
      end
   end

   always_comb begin
      prdata = '0;
      if (accessCycle && validRead) begin
         if (flagsRead) begin
            prdata = {{(16 - $bits(aluPkg::aluFlags_t)){1'b0}}, flags};
         end else begin
            prdata = {{(16 - `DATA_WIDTH){1'b0}}, bus.operandA}; // upper byte zero
         end
      end
   end

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps
`include "datapath_config.svh"

module registerFile (
   input  logic         clock,
   input  logic         reset,
   regAccessBus.storage bus
);

   logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
   logic [`DATA_WIDTH-1:0] currentValue;
   logic [`DATA_WIDTH-1:0] nextValue;

   assign currentValue = regs[bus.destination];

   // new value for the destination register
   always_comb begin
      if (bus.useAlu) begin
         nextValue = bus.result;
      end else begin
         case (bus.regFun)
            commandPkg::funClear:     nextValue = '0;
            commandPkg::funLoad:      nextValue = bus.immediate;
            commandPkg::funDecrement: nextValue = currentValue - `DATA_WIDTH'(1); // 0 wraps to 255
            commandPkg::funIncrement: nextValue = currentValue + `DATA_WIDTH'(1);
            default:                  nextValue = currentValue;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         regs <= '{default: '0};
      end else if (bus.writeEnable) begin
         regs[bus.destination] <= nextValue;
      end
   end

   // both read ports are combinational
   assign bus.operandA = regs[bus.sourceA];
   assign bus.operandB = regs[bus.sourceB];

endmodule

// File: hw/aluCore.sv
`timescale 1ns/1ps
`include "datapath_config.svh"

module aluCore (
   input  logic              clock,
   input  logic              reset,
   regAccessBus.compute      bus,
   output aluPkg::aluFlags_t flags
);

   localparam int MSB = `DATA_WIDTH - 1;

   aluPkg::aluFlags_t flagReg;
   aluPkg::aluFlags_t nextFlags;

   logic [`DATA_WIDTH-1:0] opA;
   logic [`DATA_WIDTH-1:0] opB;
   logic [`DATA_WIDTH-1:0] aluResult;
   logic [`DATA_WIDTH:0]   sum;       // extra bit holds the carry out
   logic                   validOp;

   assign opA = bus.operandA;
   assign opB = bus.operandB;

   always_comb begin
      aluResult = '0;
      sum       = '0;
      nextFlags = flagReg;  // flags not touched by an op keep their value
      validOp   = 1'b1;
      case (bus.aluOp)
         aluPkg::aluPassA: aluResult = opA;
         aluPkg::aluPassB: aluResult = opB;
         aluPkg::aluNotA:  aluResult = ~opA;
         aluPkg::aluAdd: begin
            sum = {1'b0, opA} + {1'b0, opB} + {{`DATA_WIDTH{1'b0}}, flagReg.carry};
            aluResult          = sum[MSB:0];
            nextFlags.carry    = sum[`DATA_WIDTH];
            // same operand signs, different result sign
            nextFlags.overflow = (opA[MSB] == opB[MSB]) & (aluResult[MSB] != opA[MSB]);
         end
         aluPkg::aluSub: begin
            sum = {1'b0, opA} + {1'b0, ~opB} + `DATA_WIDTH'(1);
            aluResult          = sum[MSB:0];
            nextFlags.carry    = sum[`DATA_WIDTH];
            nextFlags.overflow = (opA[MSB] != opB[MSB]) & (aluResult[MSB] != opA[MSB]);
         end
         aluPkg::aluAnd: aluResult = opA & opB;
         aluPkg::aluOr:  aluResult = opA | opB;
         aluPkg::aluXor: aluResult = opA ^ opB;
         aluPkg::aluShiftLeft: begin
            aluResult       = opA << 1;
            nextFlags.carry = opA[MSB];  // bit shifted out
         end
         aluPkg::aluShiftRight: begin
            aluResult       = opA >> 1;
            nextFlags.carry = opA[0];
         end
         aluPkg::aluShiftRightArith: begin
            // sign bit repeats, carry stays
            aluResult = {opA[MSB], opA[MSB:1]};
         end
         default: begin
            validOp = 1'b0;  // unused codes leave the flags alone
         end
      endcase

      if (validOp) begin
         nextFlags.zero     = aluResult == '0;
         nextFlags.negative = aluResult[MSB];
      end
   end

   assign bus.result = aluResult;

   // flag register written only on ALU-form commands
   always_ff @(posedge clock) begin
      if (reset) begin
         flagReg <= '0;
      end else if (bus.writeEnable && bus.useAlu) begin
         flagReg <= nextFlags;
      end
   end

   assign flags = flagReg;

endmodule

// File: hw/microDatapath.sv
`timescale 1ns/1ps
`include "datapath_config.svh"

module microDatapath (
   input  logic                       clock,
   input  logic                       reset,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [`APB_ADDR_WIDTH-1:0] paddr,
   input  logic [15:0]                pwdata,
   output logic [15:0]                prdata,
   output logic                       pready,
   output logic                       pslverr
);

   regAccessBus bus ();

   aluPkg::aluFlags_t flags;  // flag register read back over APB

   // decodes host commands and serves reads
   apbCommandPort commandPort (
      .clock   (clock),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .flags   (flags),
      .bus     (bus.commander)
   );

   registerFile regFile (
      .clock (clock),
      .reset (reset),
      .bus   (bus.storage)
   );

   // result loops back into the register file
   aluCore alu (
      .clock (clock),
      .reset (reset),
      .bus   (bus.compute),
      .flags (flags)
   );

endmodule

// File: tests/datapathTbTasks.svh
`ifndef DATAPATH_TB_TASKS_SVH
`define DATAPATH_TB_TASKS_SVH

// one APB transfer started one step after a rising edge
task automatic apbTransfer(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
      input logic [15:0] wdata, output logic [15:0] rdata, output logic err,
      output int cycles);
   logic done;
   rdata   = '0;
   err     = 1'b0;
   cycles  = 0;
   done    = 1'b0;
   psel    = 1'b1;  // setup cycle
   penable = 1'b0;
   pwrite  = write;
   paddr   = addr;
   pwdata  = wdata;
   @(posedge clock);
   #1 penable = 1'b1;
   while (!done) begin
      @(negedge clock);  // pready settled mid-cycle
      cycles++;
      if (pready) begin
         done  = 1'b1;
         rdata = prdata;
         err   = pslverr;
      end else if (cycles >= ACCESS_TIMEOUT) begin
         stopRun($sformatf("timeout: pready stayed low for %0d access cycles at address %0d",
            cycles, addr));
      end
      @(posedge clock);
      #1;
   end
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic apbWrite(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [15:0] data,
      output logic err, output int cycles);
   logic [15:0] ignored;
   apbTransfer(1'b1, addr, data, ignored, err, cycles);
endtask

task automatic apbRead(input logic [`APB_ADDR_WIDTH-1:0] addr, output logic [15:0] data,
      output logic err, output int cycles);
   apbTransfer(1'b0, addr, 16'h0000, data, err, cycles);
endtask

task automatic compareData(input string what, input logic [`DATA_WIDTH-1:0] actual,
      input logic [`DATA_WIDTH-1:0] expected);
   if (actual !== expected) begin
      stopRun($sformatf("MISMATCH at %0d ns: %s is %h, expected %h",
         $time, what, actual, expected));
   end
endtask

task automatic compareFlags(input string what, input aluPkg::aluFlags_t actual,
      input aluPkg::aluFlags_t expected);
   if (actual !== expected) begin
      stopRun($sformatf("MISMATCH at %0d ns: %s are %b (z c n v), expected %b",
         $time, what, actual, expected));
   end
endtask

task automatic compareError(input string what, input logic actual, input logic expected);
   if (actual !== expected) begin
      stopRun($sformatf("MISMATCH at %0d ns: %s pslverr is %b, expected %b",
         $time, what, actual, expected));
   end
endtask

task automatic compareCount(input string what, input int actual, input int expected);
   if (actual != expected) begin
      stopRun($sformatf("MISMATCH at %0d ns: %s took %0d access cycles, expected %0d",
         $time, what, actual, expected));
   end
endtask

// command words laid out bit by bit
function automatic logic [15:0] encodeRegOp(input commandPkg::regFun_t fun,
      input commandPkg::regIndex_t dest, input logic [`DATA_WIDTH-1:0] imm);
   return {1'b1, fun, 2'b00, dest, 1'b0, imm};
endfunction

function automatic logic [15:0] encodeAluOp(input aluPkg::aluOp_t op,
      input commandPkg::regIndex_t dest, input commandPkg::regIndex_t srcA,
      input commandPkg::regIndex_t srcB);
   return {1'b0, op, dest, srcA, srcB, 5'b00000};
endfunction

function automatic logic [`DATA_WIDTH-1:0] modelRegFun(input commandPkg::regFun_t fun,
      input logic [`DATA_WIDTH-1:0] current, input logic [`DATA_WIDTH-1:0] imm);
   case (fun)
      commandPkg::funClear:     return '0;
      commandPkg::funLoad:      return imm;
      commandPkg::funDecrement: return current - `DATA_WIDTH'(1);
      default:                  return current + `DATA_WIDTH'(1);
   endcase
endfunction

function automatic logic [`DATA_WIDTH-1:0] modelAlu(input aluPkg::aluOp_t op,
      input logic [`DATA_WIDTH-1:0] a, input logic [`DATA_WIDTH-1:0] b,
      input aluPkg::aluFlags_t flagsIn, output aluPkg::aluFlags_t flagsOut);
   logic [`DATA_WIDTH-1:0] r;
   int                     wide;
   flagsOut = flagsIn;
   r        = '0;
   case (op)
      aluPkg::aluPassA: r = a;
      aluPkg::aluPassB: r = b;
      aluPkg::aluNotA:  r = ~a;
      aluPkg::aluAdd: begin
         wide              = int'(a) + int'(b) + int'(flagsIn.carry);
         r                 = wide[`DATA_WIDTH-1:0];
         flagsOut.carry    = wide > 255;
         wide              = int'($signed(a)) + int'($signed(b)) + int'(flagsIn.carry);
         flagsOut.overflow = (wide > 127) || (wide < -128);  // outside signed range
      end
      aluPkg::aluSub: begin
         r                 = a - b;
         flagsOut.carry    = a >= b;  // set when nothing is borrowed
         wide              = int'($signed(a)) - int'($signed(b));
         flagsOut.overflow = (wide > 127) || (wide < -128);
      end
      aluPkg::aluAnd: r = a & b;
      aluPkg::aluOr:  r = a | b;
      aluPkg::aluXor: r = a ^ b;
      aluPkg::aluShiftLeft: begin
         r              = {a[`DATA_WIDTH-2:0], 1'b0};
         flagsOut.carry = a[`DATA_WIDTH-1];
      end
      aluPkg::aluShiftRight: begin
         r              = {1'b0, a[`DATA_WIDTH-1:1]};
         flagsOut.carry = a[0];
      end
      default: r = $signed(a) >>> 1;  // arithmetic shift keeps carry
   endcase
   flagsOut.zero     = r == '0;
   flagsOut.negative = r[`DATA_WIDTH-1];
   return r;
endfunction

`endif

// File: tests/datapathTb.sv
`timescale 1ns/1ps
`include "datapath_config.svh"

module datapathTb;

   localparam int ACCESS_TIMEOUT = 16;  // access cycles before a transfer is given up

   logic                       clock;
   logic                       reset;
   logic                       psel;
   logic                       penable;
   logic                       pwrite;
   logic [`APB_ADDR_WIDTH-1:0] paddr;
   logic [15:0]                pwdata;
   logic [15:0]                prdata;
   logic                       pready;
   logic                       pslverr;

   integer seed;

   // expected state following every accepted command
   logic [`DATA_WIDTH-1:0] shadowRegs [`REG_COUNT];
   aluPkg::aluFlags_t      shadowFlags;

   microDatapath u_dut (
      .clock   (clock),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   always #2 clock = ~clock;

   task automatic stopRun(input string reason);
      $display("%s", reason);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

`include "datapathTbTasks.svh"

   task automatic readRegister(input commandPkg::regIndex_t idx,
         output logic [`DATA_WIDTH-1:0] value);
      logic [15:0] data;
      logic        err;
      int          cycles;
      apbRead(`APB_ADDR_WIDTH'(idx), data, err, cycles);
      compareError("register read", err, 1'b0);
      compareCount("register read", cycles, 1);
      compareData("upper byte of register read", data[15:8], 8'h00);
      value = data[`DATA_WIDTH-1:0];
   endtask

   task automatic readFlags(output aluPkg::aluFlags_t value);
      logic [15:0] data;
      logic        err;
      int          cycles;
      apbRead(`APB_ADDR_WIDTH'(`ADDR_FLAGS), data, err, cycles);
      compareError("flag read", err, 1'b0);
      value = aluPkg::aluFlags_t'(data[3:0]);
   endtask

   task automatic runRegOp(input commandPkg::regFun_t fun, input commandPkg::regIndex_t dest,
         input logic [`DATA_WIDTH-1:0] imm);
      logic err;
      int   cycles;
      apbWrite(`APB_ADDR_WIDTH'(`ADDR_COMMAND), encodeRegOp(fun, dest, imm), err, cycles);
      compareError("register-form write", err, 1'b0);
      compareCount("register-form write", cycles, 2);  // one wait state
      shadowRegs[dest] = modelRegFun(fun, shadowRegs[dest], imm);
   endtask

   task automatic runAluOp(input aluPkg::aluOp_t op, input commandPkg::regIndex_t dest,
         input commandPkg::regIndex_t srcA, input commandPkg::regIndex_t srcB);
      logic              err;
      int                cycles;
      aluPkg::aluFlags_t newFlags;
      apbWrite(`APB_ADDR_WIDTH'(`ADDR_COMMAND), encodeAluOp(op, dest, srcA, srcB), err, cycles);
      compareError("ALU-form write", err, 1'b0);
      compareCount("ALU-form write", cycles, 2);
      shadowRegs[dest] = modelAlu(op, shadowRegs[srcA], shadowRegs[srcB], shadowFlags, newFlags);
      shadowFlags      = newFlags;
   endtask

   // reads back all four registers and the flags
   task automatic checkState(input string where);
      logic [`DATA_WIDTH-1:0] value;
      aluPkg::aluFlags_t      flagValue;
      for (int i = 0; i < `REG_COUNT; i++) begin
         readRegister(commandPkg::regIndex_t'(i), value);
         compareData($sformatf("%s, R%0d", where, i), value, shadowRegs[i]);
      end
      readFlags(flagValue);
      compareFlags($sformatf("%s, flags", where), flagValue, shadowFlags);
   endtask

   task automatic testRegisterForm();
      logic [`DATA_WIDTH-1:0] value;
      for (int i = 0; i < `REG_COUNT; i++) begin
         runRegOp(commandPkg::funLoad, commandPkg::regIndex_t'(i), 8'h3C + 8'(i * 17));
         runRegOp(commandPkg::funIncrement, commandPkg::regIndex_t'(i), 8'hA5);
         runRegOp(commandPkg::funDecrement, commandPkg::regIndex_t'(i), 8'h5A);
         runRegOp(commandPkg::funDecrement, commandPkg::regIndex_t'(i), 8'h00);
         checkState($sformatf("register functions on R%0d", i));
      end
      runRegOp(commandPkg::funClear, 2'd2, 8'hFF);
      runRegOp(commandPkg::funDecrement, 2'd2, 8'h00);
      readRegister(2'd2, value);
      compareData("decrement from zero", value, 8'hFF);
      runRegOp(commandPkg::funIncrement, 2'd2, 8'h00);
      checkState("increment from 255");
      for (int i = 0; i < `REG_COUNT; i++) begin
         runRegOp(commandPkg::funClear, commandPkg::regIndex_t'(i), 8'h77);
      end
      checkState("clear");
   endtask

   task automatic testAluForm();
      aluPkg::aluOp_t ops [11];
      ops = '{aluPkg::aluPassA, aluPkg::aluPassB, aluPkg::aluNotA, aluPkg::aluAdd,
              aluPkg::aluSub, aluPkg::aluAnd, aluPkg::aluOr, aluPkg::aluXor,
              aluPkg::aluShiftLeft, aluPkg::aluShiftRight, aluPkg::aluShiftRightArith};
      for (int i = 0; i < 11; i++) begin
         for (int r = 0; r < `REG_COUNT; r++) begin
            runRegOp(commandPkg::funLoad, commandPkg::regIndex_t'(r), 8'($random(seed)));
         end
         runAluOp(ops[i], commandPkg::regIndex_t'(i % 4), commandPkg::regIndex_t'((i + 1) % 4),
            commandPkg::regIndex_t'((i + 3) % 4));
         checkState($sformatf("ALU %s", ops[i].name()));
      end
   endtask

   task automatic testFlags();
      logic [`DATA_WIDTH-1:0] value;
      aluPkg::aluFlags_t      flagValue;
      runRegOp(commandPkg::funLoad, 2'd0, 8'hF0);
      runRegOp(commandPkg::funLoad, 2'd1, 8'h20);
      runRegOp(commandPkg::funLoad, 2'd3, 8'h02);
      runAluOp(aluPkg::aluShiftRight, 2'd3, 2'd3, 2'd3);  // clears carry
      runAluOp(aluPkg::aluAdd, 2'd2, 2'd0, 2'd1);         // F0 + 20 carries out
      readFlags(flagValue);
      compareFlags("carry out of add", flagValue, 4'b0100);
      runAluOp(aluPkg::aluAdd, 2'd2, 2'd1, 2'd1);
      readRegister(2'd2, value);
      compareData("add with stored carry", value, 8'h41);
      runRegOp(commandPkg::funLoad, 2'd0, 8'h80);
      runRegOp(commandPkg::funLoad, 2'd1, 8'h01);
      runAluOp(aluPkg::aluSub, 2'd2, 2'd0, 2'd1);         // 80 - 01 overflows
      readFlags(flagValue);
      compareFlags("sub overflow", flagValue, 4'b0101);
      runAluOp(aluPkg::aluShiftRight, 2'd3, 2'd0, 2'd0);
      runRegOp(commandPkg::funLoad, 2'd0, 8'h81);
      runAluOp(aluPkg::aluShiftLeft, 2'd3, 2'd0, 2'd0);
      readFlags(flagValue);
      compareFlags("shift left carry out", flagValue, 4'b0101);
      runRegOp(commandPkg::funLoad, 2'd0, 8'h82);  // even, so carry cannot follow bit 0
      runRegOp(commandPkg::funIncrement, 2'd3, 8'h00);
      readFlags(flagValue);
      compareFlags("register form", flagValue, 4'b0101);  // untouched
      runAluOp(aluPkg::aluShiftRightArith, 2'd3, 2'd0, 2'd0);
      readFlags(flagValue);
      compareFlags("arithmetic shift right", flagValue, 4'b0111);
      checkState("flag sequence");
   endtask

   task automatic testErrors();
      logic [15:0] data;
      logic        err;
      int          cycles;
      apbWrite(4'd0, encodeRegOp(commandPkg::funLoad, 2'd0, 8'hAA), err, cycles);
      compareError("write to address 0", err, 1'b1);
      compareCount("write to address 0", cycles, 1);
      apbWrite(4'd4, encodeRegOp(commandPkg::funClear, 2'd1, 8'h00), err, cycles);
      compareError("write to the flag address", err, 1'b1);
      apbRead(4'd9, data, err, cycles);
      compareError("read of address 9", err, 1'b1);
      compareCount("read of address 9", cycles, 1);
      checkState("after failed transfers");
   endtask

   initial begin
      clock       = 1'b0;
      reset       = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      seed        = 32'h4469_c99f;
      shadowRegs  = '{default: '0};
      shadowFlags = '0;
      repeat (4) @(posedge clock);
      #1 reset = 1'b0;
      checkState("after reset");
      testRegisterForm();
      testAluForm();
      testFlags();
      testErrors();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+hw
+incdir+tests
hw/aluPkg.sv
hw/commandPkg.sv
hw/regAccessBus.sv
hw/apbCommandPort.sv
hw/registerFile.sv
hw/aluCore.sv
hw/microDatapath.sv
tests/datapathTb.sv

// File: Makefile
SOURCES := $(filter-out +%,$(shell cat filelist.f))
HEADERS := hw/datapath_config.svh tests/datapathTbTasks.svh

obj_dir/VdatapathTb: filelist.f $(SOURCES) $(HEADERS)
	verilator --binary -Wno-fatal --top-module datapathTb -f filelist.f

run: obj_dir/VdatapathTb
	./obj_dir/VdatapathTb | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
